// File: hw/mmu_pkg.sv
/* MMU shared definitions */

package mmu_pkg;

    // --------------------
    // Data types
    typedef logic [31:0] vaddr_t;       // Virtual address
    typedef logic [19:0] physad_t;      // Physical address
    typedef logic  [9:0] page_t;        // Page number
    typedef logic  [9:0] page_off_t;    // Offset within page
    typedef logic [19:0] map_entry_t;   // Page map entry, phys page in 19:10
    typedef logic  [3:0] arb_op_t;      // Request opcode
    typedef logic  [7:0] apb_addr_t;    // APB byte address
    typedef logic [31:0] apb_data_t;    // APB data

    localparam int    NUM_PAGES       = 1024;
    localparam page_t LAST_PAGE       = 10'd1023;
    localparam int    BESM6_PAGE_BITS = 5;  // Page number width in compatibility mode

    // --------------------
    // Register map
    localparam apb_addr_t REG_CTRL    = 8'h00;  // Mode bits
    localparam apb_addr_t REG_VADDR   = 8'h04;  // Virtual address
    localparam apb_addr_t REG_PGINDEX = 8'h08;  // Page index in 19:10
    localparam apb_addr_t REG_MAPDATA = 8'h0C;  // Map entry at vaddr page
    localparam apb_addr_t REG_ACCESS  = 8'h10;  // Used and dirty bits
    localparam apb_addr_t REG_REPRIO  = 8'h14;  // Reprioritize bit
    localparam apb_addr_t REG_FILL    = 8'h18;  // Fill start, busy
    localparam apb_addr_t REG_PHYSAD  = 8'h1C;  // Current translation

    localparam int CTRL_NO_PAGING_BIT = 0;
    localparam int CTRL_BESM6_BIT     = 1;
    localparam int ACC_USED_BIT       = 1;
    localparam int ACC_DIRTY_BIT      = 2;

    // --------------------
    // Opcodes that modify the page
    localparam arb_op_t OP_CCWR  = 4'd2;    // Instruction cache write
    localparam arb_op_t OP_DCWR  = 4'd4;    // Data cache write
    localparam arb_op_t OP_DWR   = 4'd10;   // Data write
    localparam arb_op_t OP_RDMWR = 4'd11;   // Read-modify-write
    localparam arb_op_t OP_BTRWR = 4'd12;   // Block transfer write

    typedef enum logic {
        FILL_IDLE,
        FILL_RUN
    } fill_state_t;

endpackage

// File: hw/mmu_regs.sv
/* MMU APB register block */

`timescale 1ns/100ps

module mmu_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  mmu_pkg::apb_addr_t i_paddr,
    input  mmu_pkg::apb_data_t i_pwdata,
    input  mmu_pkg::physad_t   i_physad,       // Translation of vaddr
    input  mmu_pkg::map_entry_t i_map_rdata,   // Map entry at vaddr page
    input  mmu_pkg::page_t     i_pg_index,
    input  logic               i_used,
    input  logic               i_dirty,
    input  logic               i_reprio,
    input  logic               i_fill_busy,
    output mmu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    output mmu_pkg::vaddr_t    o_vaddr,
    output logic               o_no_paging,
    output logic               o_besm6,
    output logic               o_map_we,
    output logic               o_pgindex_we,
    output logic               o_access_we,
    output logic               o_reprio_we,
    output logic               o_fill_start,
    output mmu_pkg::apb_data_t o_wdata
);

    logic access;       // Access phase
    logic mapped;       // Address hits the map
    logic stall;        // Page bits busy with fill
    logic wr_en;        // Write completes this cycle

    // --------------------
    // Decode
    always_comb begin
        case (i_paddr)
            mmu_pkg::REG_CTRL,
            mmu_pkg::REG_VADDR,
            mmu_pkg::REG_PGINDEX,
            mmu_pkg::REG_MAPDATA,
            mmu_pkg::REG_ACCESS,
            mmu_pkg::REG_REPRIO,
            mmu_pkg::REG_FILL,
            mmu_pkg::REG_PHYSAD: mapped = 1'b1;
            default:             mapped = 1'b0;
        endcase
    end

    assign access = i_psel & i_penable;
    assign stall  = i_fill_busy &
                    (i_paddr == mmu_pkg::REG_ACCESS || i_paddr == mmu_pkg::REG_REPRIO);

    assign o_pready  = ~(i_psel & stall);           // Wait state while fill owns the bits
    assign o_pslverr = access & ~mapped;
    assign wr_en     = access & i_pwrite & o_pready;

    assign o_map_we     = wr_en & (i_paddr == mmu_pkg::REG_MAPDATA);
    assign o_pgindex_we = wr_en & (i_paddr == mmu_pkg::REG_PGINDEX);
    assign o_access_we  = wr_en & (i_paddr == mmu_pkg::REG_ACCESS);
    assign o_reprio_we  = wr_en & (i_paddr == mmu_pkg::REG_REPRIO);
    assign o_fill_start = wr_en & (i_paddr == mmu_pkg::REG_FILL);
    assign o_wdata      = i_pwdata;

    // --------------------
    // Mode and address registers
    always_ff @(posedge clk) begin
        if (reset) begin
            o_no_paging <= 1'b0;
            o_besm6     <= 1'b0;
            o_vaddr     <= '0;
        end else if (wr_en) begin
            if (i_paddr == mmu_pkg::REG_CTRL) begin
                o_no_paging <= i_pwdata[mmu_pkg::CTRL_NO_PAGING_BIT];
                o_besm6     <= i_pwdata[mmu_pkg::CTRL_BESM6_BIT];
            end
            if (i_paddr == mmu_pkg::REG_VADDR)
                o_vaddr <= i_pwdata;
        end
    end

    // Read data, valid during access phase
    always_comb begin
        o_prdata = '0;
        case (i_paddr)
            mmu_pkg::REG_CTRL: begin
                o_prdata[mmu_pkg::CTRL_NO_PAGING_BIT] = o_no_paging;
                o_prdata[mmu_pkg::CTRL_BESM6_BIT]     = o_besm6;
            end
            mmu_pkg::REG_VADDR:   o_prdata = o_vaddr;
            mmu_pkg::REG_PGINDEX: o_prdata[19:10] = i_pg_index;
            mmu_pkg::REG_MAPDATA: o_prdata[19:0] = i_map_rdata;
            mmu_pkg::REG_ACCESS: begin
                o_prdata[mmu_pkg::ACC_USED_BIT]  = i_used;
                o_prdata[mmu_pkg::ACC_DIRTY_BIT] = i_dirty;
            end
            mmu_pkg::REG_REPRIO:  o_prdata[0] = i_reprio;
            mmu_pkg::REG_FILL:    o_prdata[0] = i_fill_busy;
            mmu_pkg::REG_PHYSAD:  o_prdata[19:0] = i_physad;
            default:              o_prdata = '0;   // Unmapped
        endcase
    end

endmodule

// File: hw/page_translator.sv
/* Page map and translation */

`timescale 1ns/100ps

module page_translator (
    input  logic                clk,
    input  mmu_pkg::vaddr_t     i_vaddr,
    input  logic                i_no_paging,   // Bypass the map
    input  logic                i_besm6,       // Compatibility page number
    input  logic                i_map_we,
    input  mmu_pkg::map_entry_t i_map_wdata,
    output mmu_pkg::map_entry_t o_map_rdata,
    output mmu_pkg::physad_t    o_physad
);

    mmu_pkg::map_entry_t pg_map [mmu_pkg::NUM_PAGES];  // Page map memory

    mmu_pkg::page_t      map_page;      // Page for map access, always 19:10
    mmu_pkg::page_t      pg_virt;       // Virtual page in current mode
    mmu_pkg::page_t      pg_phys;       // Translated page
    mmu_pkg::page_off_t  pg_offset;
    mmu_pkg::map_entry_t virt_entry;

    assign map_page  = i_vaddr[19:10];
    assign pg_offset = i_vaddr[9:0];

    // --------------------
    // Map access
    always_ff @(posedge clk) begin
        if (i_map_we)
            pg_map[map_page] <= i_map_wdata;
    end

    assign o_map_rdata = pg_map[map_page];

    // --------------------
    // Translation
    always_comb begin
        if (i_besm6)
            pg_virt = mmu_pkg::page_t'(i_vaddr[10 +: mmu_pkg::BESM6_PAGE_BITS]);
        else
            pg_virt = i_vaddr[19:10];  // Full page number
    end

    assign virt_entry = pg_map[pg_virt];

    assign pg_phys  = i_no_paging ? pg_virt : virt_entry[19:10];
    assign o_physad = {pg_phys, pg_offset};

endmodule

// File: hw/page_status.sv
/* Page status and request logic */

`timescale 1ns/100ps

module page_status (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_req,
    input  mmu_pkg::arb_op_t   i_arb_op,
    input  mmu_pkg::vaddr_t    i_vaddr,
    input  mmu_pkg::physad_t   i_physad,
    input  logic               i_pgindex_we,
    input  logic               i_access_we,
    input  logic               i_reprio_we,
    input  logic               i_fill_start,
    input  mmu_pkg::apb_data_t i_wdata,
    output logic               o_ack,
    output logic               o_fault,
    output mmu_pkg::physad_t   o_physad,
    output mmu_pkg::page_t     o_pg_index,
    output logic               o_used,
    output logic               o_dirty,
    output logic               o_reprio,
    output logic               o_fill_busy
);

    logic pg_used   [mmu_pkg::NUM_PAGES];  // Page referenced
    logic pg_dirty  [mmu_pkg::NUM_PAGES];  // Page modified
    logic pg_reprio [mmu_pkg::NUM_PAGES];  // Reprioritize request

    mmu_pkg::page_t      pg_index;     // Current physical page
    mmu_pkg::page_t      phys_page;
    mmu_pkg::page_t      fill_cnt;
    mmu_pkg::fill_state_t fill_state;

    logic req_accept;   // Request taken this cycle
    logic req_mark;     // Accepted and not faulting
    logic addr_zero;
    logic is_write_op;

    assign o_fill_busy = (fill_state == mmu_pkg::FILL_RUN);
    assign req_accept  = i_req & ~o_fill_busy & ~o_ack;  // Requester drops after ack
    assign addr_zero   = (i_vaddr == '0);
    assign req_mark    = req_accept & ~addr_zero;      // Fault leaves state alone
    assign phys_page   = i_physad[19:10];

    always_comb begin
        case (i_arb_op)
            mmu_pkg::OP_CCWR,
            mmu_pkg::OP_DCWR,
            mmu_pkg::OP_DWR,
            mmu_pkg::OP_RDMWR,
            mmu_pkg::OP_BTRWR: is_write_op = 1'b1;
            default:           is_write_op = 1'b0;
        endcase
    end

    // --------------------
    // Request handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            o_ack    <= 1'b0;
            o_fault  <= 1'b0;
            pg_index <= '0;
        end else begin
            o_ack <= req_accept;            // One-cycle pulse
            if (req_accept)
                o_fault <= addr_zero;
            if (req_mark)
                pg_index <= phys_page;      // Request wins over APB
            else if (i_pgindex_we)
                pg_index <= i_wdata[19:10];
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept)
            o_physad <= i_physad;           // Held until next ack
    end

    // Used and dirty, request marking last so it wins
    always_ff @(posedge clk) begin
        if (i_access_we) begin
            pg_used[pg_index]  <= i_wdata[mmu_pkg::ACC_USED_BIT];
            pg_dirty[pg_index] <= i_wdata[mmu_pkg::ACC_DIRTY_BIT];
        end
        if (req_mark) begin
            pg_used[phys_page] <= 1'b1;
            if (is_write_op)
                pg_dirty[phys_page] <= 1'b1;
        end
    end

    // --------------------
    // Fill sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_state <= mmu_pkg::FILL_IDLE;
            fill_cnt   <= '0;
        end else begin
            case (fill_state)
                mmu_pkg::FILL_IDLE: begin
                    if (i_fill_start) begin
                        fill_state <= mmu_pkg::FILL_RUN;
                        fill_cnt   <= pg_index;     // Start at current page
                    end
                end
                mmu_pkg::FILL_RUN: begin
                    if (fill_cnt == mmu_pkg::LAST_PAGE)
                        fill_state <= mmu_pkg::FILL_IDLE;
                    else
                        fill_cnt <= fill_cnt + 1'b1;
                end
                default: fill_state <= mmu_pkg::FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_fill_busy)
            pg_reprio[fill_cnt] <= 1'b1;            // One bit per cycle
        else if (i_reprio_we)
            pg_reprio[pg_index] <= i_wdata[0];
    end

    assign o_pg_index = pg_index;
    assign o_used     = pg_used[pg_index];
    assign o_dirty    = pg_dirty[pg_index];
    assign o_reprio   = pg_reprio[pg_index];

endmodule

// File: hw/mmu_top.sv
/* MMU top level */

`timescale 1ns/100ps

module mmu_top (
    input  logic               clk,
    input  logic               reset,
    // APB slave
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  mmu_pkg::apb_addr_t i_paddr,
    input  mmu_pkg::apb_data_t i_pwdata,
    output mmu_pkg::apb_data_t o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    // Request port
    input  logic               i_req,
    input  mmu_pkg::arb_op_t   i_arb_op,
    output logic               o_ack,
    output mmu_pkg::physad_t   o_physad,
    output logic               o_fault
);

    mmu_pkg::vaddr_t     vaddr;
    mmu_pkg::physad_t    physad;        // Live translation
    mmu_pkg::map_entry_t map_rdata;
    mmu_pkg::page_t      pg_index;
    mmu_pkg::apb_data_t  wdata;
    logic no_paging, besm6;
    logic used, dirty, reprio, fill_busy;
    logic map_we, pgindex_we, access_we, reprio_we, fill_start;

    mmu_regs i_mmu_regs (
        .clk, .reset,
        .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
        .i_physad(physad), .i_map_rdata(map_rdata), .i_pg_index(pg_index),
        .i_used(used), .i_dirty(dirty), .i_reprio(reprio), .i_fill_busy(fill_busy),
        .o_prdata, .o_pready, .o_pslverr,
        .o_vaddr(vaddr), .o_no_paging(no_paging), .o_besm6(besm6),
        .o_map_we(map_we), .o_pgindex_we(pgindex_we), .o_access_we(access_we),
        .o_reprio_we(reprio_we), .o_fill_start(fill_start), .o_wdata(wdata)
    );

    page_translator i_page_translator (
        .clk,
        .i_vaddr(vaddr), .i_no_paging(no_paging), .i_besm6(besm6),
        .i_map_we(map_we), .i_map_wdata(wdata[19:0]),
        .o_map_rdata(map_rdata), .o_physad(physad)
    );

    page_status i_page_status (
        .clk, .reset,
        .i_req, .i_arb_op, .i_vaddr(vaddr), .i_physad(physad),
        .i_pgindex_we(pgindex_we), .i_access_we(access_we),
        .i_reprio_we(reprio_we), .i_fill_start(fill_start), .i_wdata(wdata),
        .o_ack, .o_fault, .o_physad, .o_pg_index(pg_index),
        .o_used(used), .o_dirty(dirty), .o_reprio(reprio), .o_fill_busy(fill_busy)
    );

endmodule

// File: verif/mmu_ref.svh
/* MMU reference model */

// --------------------
// Expected contents
mmu_pkg::map_entry_t ref_map [mmu_pkg::NUM_PAGES];         // Page map as written
logic                ref_reprio [mmu_pkg::NUM_PAGES];      // Reprioritize bits
bit                  ref_prio_known [mmu_pkg::NUM_PAGES];  // Bit has a defined value

// Virtual page from the mode, then map lookup unless paging is off
function automatic mmu_pkg::physad_t ref_physad(input mmu_pkg::vaddr_t va,
                                                input logic no_paging,
                                                input logic besm6);
    mmu_pkg::page_t vpage;
    mmu_pkg::page_t ppage;
    if (besm6)
        vpage = {5'b00000, va[14:10]};     // 5-bit page number, zero-extended
    else
        vpage = va[19:10];
    if (no_paging)
        ppage = vpage;                     // Identity mapping
    else
        ppage = ref_map[vpage][19:10];
    return {ppage, va[9:0]};
endfunction

// Opcodes that modify the page
function automatic logic ref_is_dirty_op(input mmu_pkg::arb_op_t op);
    return op inside {mmu_pkg::OP_CCWR, mmu_pkg::OP_DCWR, mmu_pkg::OP_DWR,
                      mmu_pkg::OP_RDMWR, mmu_pkg::OP_BTRWR};
endfunction

// File: verif/mmu_tb.sv
/* MMU testbench */

`timescale 1ns/100ps

module mmu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_XLAT       = 32;     // Translations per mode
    localparam int N_REQ        = 48;     // Requests without fault
    localparam int N_PRIO       = 12;     // Reprioritize writes before the fill
    localparam int TEST_CYCLES  = RESET_CYCLES + mmu_pkg::NUM_PAGES * 10
                                  + 3 * (2 + N_XLAT * 4) + N_REQ * 17 + N_PRIO * 10 + 200;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2 * mmu_pkg::NUM_PAGES;
    localparam mmu_pkg::apb_addr_t SNAP_ADDR [5] = '{mmu_pkg::REG_CTRL, mmu_pkg::REG_VADDR,
        mmu_pkg::REG_PGINDEX, mmu_pkg::REG_MAPDATA, mmu_pkg::REG_PHYSAD};

    logic               clk = 1'b0;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    mmu_pkg::apb_addr_t paddr;
    mmu_pkg::apb_data_t pwdata;
    mmu_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;
    logic               req;
    mmu_pkg::arb_op_t   arb_op;
    logic               ack;
    logic               fault;
    mmu_pkg::physad_t   physad;

    integer           seed = 32759;
    logic             last_slverr;       // Slave error of the last transfer
    int               last_waits;        // Wait states of the last transfer
    mmu_pkg::physad_t exp_physad;        // Expected on next acknowledge
    logic             exp_fault;
    int               ack_cnt = 0;

    `include "mmu_ref.svh"

    mmu_top i_mmu_top (
        .clk, .reset,
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .i_req(req), .i_arb_op(arb_op),
        .o_ack(ack), .o_physad(physad), .o_fault(fault)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------
    // Helpers
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic mmu_pkg::apb_data_t access_word(input logic used, input logic dirty);
        mmu_pkg::apb_data_t w;
        w = '0;
        w[mmu_pkg::ACC_USED_BIT]  = used;
        w[mmu_pkg::ACC_DIRTY_BIT] = dirty;
        return w;
    endfunction

    // Entered and left on a falling edge
    task automatic transfer(input logic wr, input mmu_pkg::apb_addr_t addr,
                            input mmu_pkg::apb_data_t wdata,
                            output mmu_pkg::apb_data_t rdata);
        psel    = 1'b1;                  // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable    = 1'b1;
        last_waits = 0;
        #10;
        while (!pready) begin            // Wait states during a fill
            last_waits = last_waits + 1;
            @(negedge clk);
            #10;
        end
        rdata       = prdata;
        last_slverr = pslverr;
        @(negedge clk);                  // Completed at the rising edge
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input mmu_pkg::apb_addr_t addr, input mmu_pkg::apb_data_t data);
        mmu_pkg::apb_data_t discard;
        transfer(1'b1, addr, data, discard);
    endtask

    task automatic apb_read(input mmu_pkg::apb_addr_t addr, output mmu_pkg::apb_data_t data);
        transfer(1'b0, addr, '0, data);
    endtask

    task automatic do_request(input mmu_pkg::arb_op_t op);
        req    = 1'b1;
        arb_op = op;
        do
            @(negedge clk);
        while (ack !== 1'b1);
        req = 1'b0;                      // Low for at least a cycle
        @(negedge clk);
        check("o_ack pulse width", ack, 1'b0);
    endtask

    // Acknowledge checker
    always @(negedge clk) begin
        if (!reset && ack === 1'b1) begin
            check("o_fault", fault, exp_fault);
            check("o_physad", physad, exp_physad);
            ack_cnt = ack_cnt + 1;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

    // --------------------
    // Stimulus
    initial begin : stimulus
        mmu_pkg::apb_data_t rd;
        mmu_pkg::apb_data_t rnd;
        mmu_pkg::vaddr_t    va;
        mmu_pkg::arb_op_t   op;
        mmu_pkg::page_t     pg;
        mmu_pkg::page_t     fill_page;
        mmu_pkg::physad_t   pa;
        logic [1:0]         mode;        // Bit 1 besm6, bit 0 no paging
        mmu_pkg::apb_data_t snap [5];

        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        req     = 1'b0;
        arb_op  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // After reset
        check("o_pready", pready, 1'b1);
        check("o_ack", ack, 1'b0);
        apb_read(mmu_pkg::REG_CTRL, rd);
        check("REG_CTRL", rd, 32'h0);
        apb_read(mmu_pkg::REG_VADDR, rd);
        check("REG_VADDR", rd, 32'h0);
        apb_read(mmu_pkg::REG_PGINDEX, rd);
        check("REG_PGINDEX", rd, 32'h0);
        apb_read(mmu_pkg::REG_FILL, rd);
        check("REG_FILL", rd, 32'h0);

        // Whole page map, read back
        for (int p = 0; p < mmu_pkg::NUM_PAGES; p++) begin
            rnd = $random(seed);
            ref_map[p] = rnd[19:0];
            apb_write(mmu_pkg::REG_VADDR, 32'(p) << 10);
            apb_write(mmu_pkg::REG_MAPDATA, rnd);
            apb_read(mmu_pkg::REG_MAPDATA, rd);
            check("REG_MAPDATA", rd, {12'h0, ref_map[p]});
        end

        // Translation in normal, besm6 and no paging mode
        for (int m = 0; m < 3; m++) begin
            mode = (m == 0) ? 2'b00 : (m == 1) ? 2'b10 : 2'b01;
            apb_write(mmu_pkg::REG_CTRL, {30'h0, mode});
            repeat (N_XLAT) begin
                va = $random(seed);
                apb_write(mmu_pkg::REG_VADDR, va);
                apb_read(mmu_pkg::REG_PHYSAD, rd);
                pa = ref_physad(va, mode[mmu_pkg::CTRL_NO_PAGING_BIT],
                                mode[mmu_pkg::CTRL_BESM6_BIT]);
                check("REG_PHYSAD", rd, {12'h0, pa});
            end
        end

        // Requests in random modes
        for (int n = 0; n < N_REQ; n++) begin
            mode = 2'($random(seed));
            va   = $random(seed);
            if (va == '0)
                va = 32'h1;
            op = 4'($random(seed));
            pa = ref_physad(va, mode[mmu_pkg::CTRL_NO_PAGING_BIT],
                            mode[mmu_pkg::CTRL_BESM6_BIT]);
            pg = pa[19:10];
            apb_write(mmu_pkg::REG_CTRL, {30'h0, mode});
            apb_write(mmu_pkg::REG_VADDR, va);
            apb_write(mmu_pkg::REG_PGINDEX, {12'h0, pg, 10'h0});
            apb_write(mmu_pkg::REG_ACCESS, access_word(1'b0, 1'b0));
            apb_write(mmu_pkg::REG_PGINDEX, {12'h0, ~pg, 10'h0});  // Request must reload it
            exp_physad = pa;
            exp_fault  = 1'b0;
            do_request(op);
            apb_read(mmu_pkg::REG_PGINDEX, rd);
            check("REG_PGINDEX", rd, {12'h0, pg, 10'h0});
            apb_read(mmu_pkg::REG_ACCESS, rd);
            check("REG_ACCESS", rd, access_word(1'b1, ref_is_dirty_op(op)));
        end

        // Zero-address fault, on the page that vaddr 0 maps to
        pa = ref_physad(32'h0, 1'b0, 1'b0);
        pg = pa[19:10];
        apb_write(mmu_pkg::REG_CTRL, 32'h0);
        apb_write(mmu_pkg::REG_VADDR, 32'h0);
        apb_write(mmu_pkg::REG_PGINDEX, {12'h0, pg, 10'h0});
        apb_write(mmu_pkg::REG_ACCESS, access_word(1'b0, 1'b0));
        apb_write(mmu_pkg::REG_PGINDEX, {12'h0, ~pg, 10'h0});  // Fault must not reload it
        exp_physad = pa;
        exp_fault  = 1'b1;
        do_request(mmu_pkg::OP_DWR);
        apb_read(mmu_pkg::REG_PGINDEX, rd);
        check("REG_PGINDEX after fault", rd, {12'h0, ~pg, 10'h0});
        apb_write(mmu_pkg::REG_PGINDEX, {12'h0, pg, 10'h0});
        apb_read(mmu_pkg::REG_ACCESS, rd);
        check("REG_ACCESS after fault", rd, access_word(1'b0, 1'b0));
        check("acknowledge count", ack_cnt, N_REQ + 1);

        // Fill from a random start page
        fill_page = 10'(256 + ($random(seed) & 511));
        for (int n = 0; n < N_PRIO; n++) begin
            pg = 10'($random(seed));
            apb_write(mmu_pkg::REG_PGINDEX, {12'h0, pg, 10'h0});
            apb_write(mmu_pkg::REG_REPRIO, 32'h1);
            ref_reprio[pg]     = 1'b1;
            ref_prio_known[pg] = 1'b1;
            if (n % 2 == 1) begin            // Every other one cleared again
                apb_write(mmu_pkg::REG_REPRIO, 32'h0);
                ref_reprio[pg] = 1'b0;
            end
        end
        apb_write(mmu_pkg::REG_PGINDEX, {12'h0, fill_page, 10'h0});
        apb_write(mmu_pkg::REG_FILL, 32'h1);
        apb_read(mmu_pkg::REG_FILL, rd);
        check("REG_FILL busy", rd, 32'h1);
        apb_read(mmu_pkg::REG_REPRIO, rd);  // Held off until the fill ends
        check("REG_REPRIO stalled read", rd, 32'h1);
        check("REG_REPRIO wait states seen", last_waits > 0, 1'b1);
        rd = 32'h1;
        while (rd[0])
            apb_read(mmu_pkg::REG_FILL, rd);
        for (int p = fill_page; p < mmu_pkg::NUM_PAGES; p++) begin
            ref_reprio[p]     = 1'b1;
            ref_prio_known[p] = 1'b1;
        end
        for (int p = 0; p < mmu_pkg::NUM_PAGES; p++) begin
            if (ref_prio_known[p]) begin
                apb_write(mmu_pkg::REG_PGINDEX, 32'(p) << 10);
                apb_read(mmu_pkg::REG_REPRIO, rd);
                check("REG_REPRIO", rd, {31'h0, ref_reprio[p]});
            end
        end

        // Unmapped addresses
        apb_write(mmu_pkg::REG_CTRL, 32'h2);
        apb_write(mmu_pkg::REG_VADDR, $random(seed));
        for (int i = 0; i < 5; i++) begin
            apb_read(SNAP_ADDR[i], snap[i]);
            check("o_pslverr mapped", last_slverr, 1'b0);
        end
        apb_write(8'h20, $random(seed));
        check("o_pslverr write 0x20", last_slverr, 1'b1);
        apb_write(8'h01, $random(seed));
        check("o_pslverr write 0x01", last_slverr, 1'b1);
        apb_read(8'hFC, rd);
        check("o_pslverr read 0xFC", last_slverr, 1'b1);
        for (int i = 0; i < 5; i++) begin
            apb_read(SNAP_ADDR[i], rd);
            check("register after unmapped access", rd, snap[i]);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
hw/mmu_pkg.sv
hw/mmu_regs.sv
hw/page_translator.sv
hw/page_status.sv
hw/mmu_top.sv
verif/mmu_tb.sv

// File: Makefile
# Verilator simulation of the MMU

VERILATOR ?= verilator
TOP       ?= mmu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
